//--- compile.f
design/fetch_pkg.sv
design/fetch_wb_master.sv
design/fetch_queue.sv
design/insn_realign.sv
design/fetch_top.sv
bench/tb_imem.sv
bench/tb_fetch.sv

//--- Makefile
# Verilator build and run for the instruction fetch front end

SIM      = verilator
TOP      = tb_fetch
FILELIST = compile.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -j 0 -Mdir $(OBJDIR)

BIN  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

//--- bench/tb_fetch.sv
/* fetch front end testbench
   random stream with redirects, stalls and bus waits against a reference model */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch
    import fetch_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0100;
    localparam int              QUEUE_DEPTH = 4;
    localparam int              N_INSN      = 2000;        // transfers to check
    localparam int              CLK_PERIOD  = 4;
    localparam int              TIMEOUT_CYC = N_INSN * 40;
    localparam int              MIN_GAP     = 4;           // cycles between redirects

    logic            clk = 1'b0;
    logic            reset_n;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            insn_ready;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    fetch_insn_t     insn;
    logic            insn_valid;

    int              seed = 32'h071cefab;
    int              since_redirect = 0;
    int              n_xfer = 0;
    logic [XLEN-1:0] model_pc = RESET_PC;   // pc of next expected transfer
    logic            stall_pending = 1'b0;
    fetch_insn_t     held_insn;
    logic            hold_req = 1'b0;       // bus request must stay put
    wb_req_t         held_req;
    wb_req_t         exp_req;
    fetch_insn_t     exp_insn;

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .wb_o          (wb_req),
        .wb_i          (wb_rsp),
        .insn_o        (insn),
        .insn_valid_o  (insn_valid),
        .insn_ready_i  (insn_ready)
    );

    tb_imem imem_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_insn(input string name, input fetch_insn_t got,
                                input fetch_insn_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s pc/instr/c: got %h/%h/%h expected %h/%h/%h",
                name, got.pc, got.instr, got.compressed,
                exp.pc, exp.instr, exp.compressed));
        end
    endtask

    task automatic compare_bus(input string name, input wb_req_t got, input wb_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s cyc/stb/adr: got %h/%h/%h expected %h/%h/%h",
                name, got.cyc, got.stb, got.adr, exp.cyc, exp.stb, exp.adr));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [15:0] read_half(input logic [XLEN-1:0] addr);
        return imem_i.mem[addr[12:1]];      // same wrap as the memory model
    endfunction

    // length rule: low bits 11 mean a 32-bit instruction
    function automatic fetch_insn_t ref_insn(input logic [XLEN-1:0] pc);
        fetch_insn_t r;
        logic [15:0] lo;
        lo   = read_half(pc);
        r.pc = pc;
        if (lo[1:0] != 2'b11) begin
            r.instr      = {16'h0000, lo};
            r.compressed = 1'b1;
        end
        else begin
            r.instr      = {read_half(pc + XLEN'(2)), lo};
            r.compressed = 1'b0;
        end
        return r;
    endfunction

    // compare on every rising edge, values seen before the edge updates
    always @(posedge clk) begin
        if (reset_n) begin
            if (stall_pending) begin
                compare_bit("insn_valid_o (stalled)", insn_valid, 1'b1);
                compare_insn("insn_o (stalled)", insn, held_insn);
            end
            if (insn_valid && insn_ready) begin
                exp_insn = ref_insn(model_pc);
                compare_insn("insn_o", insn, exp_insn);
                model_pc = model_pc + (exp_insn.compressed ? XLEN'(2) : XLEN'(4));
                n_xfer++;
            end
            if (redirect) begin
                model_pc = redirect_pc;     // takes over after any same-edge transfer
            end
            stall_pending = insn_valid && !insn_ready && !redirect;
            held_insn     = insn;

            if (hold_req) begin
                compare_bus("wb_o (waiting for ack)", wb_req, held_req);
            end
            if (wb_req.stb) begin
                exp_req          = wb_req;
                exp_req.cyc      = 1'b1;    // stb only inside a cycle
                exp_req.adr[1:0] = 2'b00;
                compare_bus("wb_o", wb_req, exp_req);
            end
            hold_req = wb_req.stb && !wb_rsp.ack;
            held_req = wb_req;
        end
    end

    initial begin
        reset_n     = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        insn_ready  = 1'b0;

        @(negedge clk);
        compare_bit("wb_o.cyc in reset", wb_req.cyc, 1'b0);
        compare_bit("wb_o.stb in reset", wb_req.stb, 1'b0);
        compare_bit("insn_valid_o in reset", insn_valid, 1'b0);
        @(negedge clk);
        reset_n = 1'b1;

        while (n_xfer < N_INSN) begin
            @(negedge clk);
            insn_ready = (($random(seed) & 3) != 0);    // ready about 3/4 of cycles
            redirect   = 1'b0;
            // no redirect before the reset pc was seen
            if (n_xfer > 0 && since_redirect >= MIN_GAP && ($random(seed) & 31) == 0) begin
                redirect       = 1'b1;
                redirect_pc    = XLEN'($random(seed)) & 32'h0000_1ffe;
                since_redirect = 0;
            end
            else begin
                since_redirect++;
            end
        end

        $display("%0d instructions checked", n_xfer);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        abort_run("watchdog expired, the instruction stream stopped making progress");
    end

endmodule

`default_nettype wire

//--- bench/tb_imem.sv
/* wishbone slave memory model
   random halfword array, acks each access after 0 to 3 random wait cycles */
`timescale 1ns/10ps
`default_nettype none

module tb_imem
    import fetch_pkg::*;
#(
    parameter int SEED = 32'h071cefab
) (
    input  logic    clk,
    input  logic    reset_n,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    localparam int HW_AW  = 12;         // 8 kB, higher addresses wrap
    localparam int MEM_HW = 1 << HW_AW;

    logic [15:0]      mem [MEM_HW];     // also read by the reference model
    int               fill_seed = SEED;
    int               wait_seed = SEED + 1;
    logic             ack_r;
    logic             busy_r;           // request seen, counting wait cycles
    logic [1:0]       wait_r;
    logic [XLEN-1:0]  dat_r;
    logic [HW_AW-2:0] word_idx;

    assign word_idx = wb_req_i.adr[HW_AW:2];

    // mixed compressed and 32-bit starts from random low bits
    initial begin
        for (int i = 0; i < MEM_HW; i++) begin
            mem[i] = 16'($random(fill_seed));
        end
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_r  <= 1'b0;
            busy_r <= 1'b0;
            wait_r <= 2'd0;
        end
        else if (ack_r) begin
            ack_r <= 1'b0;              // single cycle ack
        end
        else if (busy_r) begin
            if (wait_r == 2'd0) begin
                ack_r  <= 1'b1;
                busy_r <= 1'b0;
                dat_r  <= {mem[{word_idx, 1'b1}], mem[{word_idx, 1'b0}]};  // little endian
            end
            else begin
                wait_r <= wait_r - 2'd1;
            end
        end
        else if (wb_req_i.cyc && wb_req_i.stb) begin
            busy_r <= 1'b1;
            wait_r <= 2'($random(wait_seed));
        end
    end

    assign wb_rsp_o.ack = ack_r;
    assign wb_rsp_o.dat = dat_r;

endmodule

`default_nettype wire

//--- design/fetch_top.sv
/* instruction fetch front end
   wishbone master, word queue and realigner with redirect fan-out */
`timescale 1ns/10ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC    = 32'h0000_0100,
    parameter int              QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset_n,

    input  logic            redirect_i,     // one cycle pulse from execute
    input  logic [XLEN-1:0] redirect_pc_i,

    output wb_req_t         wb_o,
    input  wb_rsp_t         wb_i,

    output fetch_insn_t     insn_o,
    output logic            insn_valid_o,
    input  logic            insn_ready_i
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic               push;
    fetch_word_t        push_word;
    logic               pop;
    fetch_word_t        head;
    logic               empty;
    logic [CNT_W-1:0]   count;              // reserves slots in the master

    fetch_wb_master #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) master_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_count_i (count),
        .wb_o          (wb_o),
        .wb_i          (wb_i),
        .push_o        (push),
        .push_word_o   (push_word)
    );

    fetch_queue #(
        .PAYLOAD_T (fetch_word_t),
        .DEPTH     (QUEUE_DEPTH)
    ) queue_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .push_i      (push),
        .push_data_i (push_word),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .count_o     (count)
    );

    // realigner keeps its own epoch copy, same redirect pulse
    insn_realign #(
        .RESET_PC (RESET_PC)
    ) realign_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .head_i        (head),
        .empty_i       (empty),
        .pop_o         (pop),
        .insn_o        (insn_o),
        .insn_valid_o  (insn_valid_o),
        .insn_ready_i  (insn_ready_i)
    );

endmodule

`default_nettype wire

//--- design/insn_realign.sv
/* instruction realigner
   turns queued words into rv32ic instructions, tracks pc and drops stale epochs */
`timescale 1ns/10ps
`default_nettype none

module insn_realign
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0100
) (
    input  logic            clk,
    input  logic            reset_n,

    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,

    input  fetch_word_t     head_i,
    input  logic            empty_i,
    output logic            pop_o,

    output fetch_insn_t     insn_o,
    output logic            insn_valid_o,
    input  logic            insn_ready_i
);

    logic [XLEN-1:0] pc_r;              // pc of the next instruction out
    epoch_t          epoch_r;           // expected epoch of queued words
    logic [15:0]     hbuf_r;            // upper halfword of the word at pc
    logic            hbuf_valid_r;

    logic [XLEN-3:0] exp_word;          // word address the head should carry
    logic            stale;
    logic            addr_ok;
    logic            head_ok;
    logic            drop;
    logic            hbuf_comp;
    logic            lo_comp;

    logic            valid;
    logic            fill;              // load empty buffer, no output
    logic            use_head;          // transfer consumes the head word
    logic            hbuf_load;         // head upper half goes to buffer
    logic [XLEN-1:0] pc_step;
    fetch_insn_t     insn;
    logic            xfer;

    // with a full buffer at pc[1] the head is already the following word
    assign exp_word  = pc_r[XLEN-1:2] + (XLEN-2)'(pc_r[1] & hbuf_valid_r);
    assign stale     = (head_i.epoch != epoch_r);
    assign addr_ok   = (head_i.addr[XLEN-1:2] == exp_word);
    assign head_ok   = !empty_i && !stale && addr_ok;
    assign drop      = !empty_i && !head_ok;    // old stream or wrong word

    assign hbuf_comp = (hbuf_r[1:0] != 2'b11);
    assign lo_comp   = (head_i.data[1:0] != 2'b11);

    always_comb begin
        valid            = 1'b0;
        fill             = 1'b0;
        use_head         = 1'b0;
        hbuf_load        = 1'b0;
        pc_step          = XLEN'(4);
        insn.pc          = pc_r;
        insn.instr       = head_i.data;
        insn.compressed  = 1'b0;

        if (!pc_r[1]) begin
            // aligned, everything comes from the head word
            valid    = head_ok;
            use_head = 1'b1;
            if (lo_comp) begin
                insn.instr      = {16'h0000, head_i.data[15:0]};
                insn.compressed = 1'b1;
                pc_step         = XLEN'(2);
                hbuf_load       = 1'b1;  // upper half is the next pc
            end
        end
        else if (!hbuf_valid_r) begin
            fill = head_ok;             // misaligned redirect target
        end
        else if (hbuf_comp) begin
            // buffered halfword is a whole instruction, head not needed
            valid           = 1'b1;
            insn.instr      = {16'h0000, hbuf_r};
            insn.compressed = 1'b1;
            pc_step         = XLEN'(2);
        end
        else begin
            // 32-bit split across words
            valid      = head_ok;
            use_head   = 1'b1;
            hbuf_load  = 1'b1;
            insn.instr = {head_i.data[15:0], hbuf_r};
        end
    end

    assign xfer  = valid && insn_ready_i;
    assign pop_o = drop || fill || (xfer && use_head);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_r         <= RESET_PC;
            epoch_r      <= '0;
            hbuf_valid_r <= 1'b0;
        end
        else if (redirect_i) begin
            pc_r         <= {redirect_pc_i[XLEN-1:1], 1'b0};
            epoch_r      <= epoch_r + epoch_t'(1);   // tracks the master copy
            hbuf_valid_r <= 1'b0;
        end
        else if (fill) begin
            hbuf_valid_r <= 1'b1;
        end
        else if (xfer) begin
            pc_r         <= pc_r + pc_step;
            hbuf_valid_r <= hbuf_load;
        end
    end

    // buffer data, qualified by hbuf_valid_r
    always_ff @(posedge clk) begin
        if (fill || (xfer && hbuf_load)) begin
            hbuf_r <= head_i.data[31:16];
        end
    end

    assign insn_o       = insn;
    assign insn_valid_o = valid;

    // stalled output holds until taken, unless the stream is redirected
    a_hold_insn: assert property (@(posedge clk) disable iff (!reset_n)
        insn_valid_o && !insn_ready_i && !redirect_i |=>
            insn_valid_o && $stable(insn_o));

endmodule

`default_nettype wire

//--- design/fetch_queue.sv
/* fetch queue
   small synchronous FIFO with a typed payload and an occupancy count */
`timescale 1ns/10ps
`default_nettype none

module fetch_queue #(
    parameter type PAYLOAD_T = logic [31:0],
    parameter int  DEPTH     = 4        // power of two, at least 2
) (
    input  logic                         clk,
    input  logic                         reset_n,

    input  logic                         push_i,
    input  PAYLOAD_T                     push_data_i,

    input  logic                         pop_i,

    output PAYLOAD_T                     head_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T             mem [DEPTH];  // storage, no reset
    logic [PTR_W-1:0]     wr_ptr_r;
    logic [PTR_W-1:0]     rd_ptr_r;
    logic [CNT_W-1:0]     count_r;

    logic                 full;
    logic                 do_pop;

    assign full   = (count_r == CNT_W'(DEPTH));
    assign do_pop = pop_i && !empty_o;  // pop on empty is ignored

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end
        else begin
            if (push_i) begin
                wr_ptr_r <= wr_ptr_r + PTR_W'(1);   // wraps, depth is 2^n
            end
            if (do_pop) begin
                rd_ptr_r <= rd_ptr_r + PTR_W'(1);
            end

            case ({push_i, do_pop})
                2'b10:   count_r <= count_r + CNT_W'(1);
                2'b01:   count_r <= count_r - CNT_W'(1);
                default: count_r <= count_r;        // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_r] <= push_data_i;
        end
    end

    assign head_o  = mem[rd_ptr_r];     // head visible without a pop
    assign empty_o = (count_r == '0);
    assign count_o = count_r;

    // producer must have reserved room
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        push_i |-> !full);

    // consumer only pops a visible head
    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- design/fetch_wb_master.sv
/* wishbone classic read master
   fetches sequential aligned words into the queue, each stamped with its epoch */
`timescale 1ns/10ps
`default_nettype none

module fetch_wb_master
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC    = 32'h0000_0100,
    parameter int              QUEUE_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               reset_n,

    input  logic                               redirect_i,
    input  logic [XLEN-1:0]                    redirect_pc_i,

    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count_i,

    output wb_req_t                            wb_o,
    input  wb_rsp_t                            wb_i,

    output logic                               push_o,
    output fetch_word_t                        push_word_o
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic            cyc_r;             // bus cycle in progress
    logic [XLEN-1:0] next_adr_r;        // address of the next cycle to start
    epoch_t          epoch_r;           // current fetch epoch
    logic [XLEN-1:0] cyc_adr_r;         // held on adr until ack
    epoch_t          cyc_epoch_r;       // epoch captured at cycle start

    logic            issue;
    logic            done;
    logic [CNT_W:0]  slots_used;        // one extra bit for the in-flight add

    // queue entries plus the word in flight must leave a free slot
    assign slots_used = {1'b0, queue_count_i} + {{CNT_W{1'b0}}, cyc_r};
    assign issue      = !cyc_r && (slots_used < (CNT_W+1)'(QUEUE_DEPTH));
    assign done       = cyc_r && wb_i.ack;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cyc_r      <= 1'b0;
            next_adr_r <= {RESET_PC[XLEN-1:2], 2'b00};
            epoch_r    <= '0;
        end
        else begin
            if (issue) begin
                cyc_r <= 1'b1;
            end
            else if (done) begin
                cyc_r <= 1'b0;          // drop cyc/stb the cycle after ack
            end

            // redirect wins over sequential advance even mid cycle
            if (redirect_i) begin
                next_adr_r <= {redirect_pc_i[XLEN-1:2], 2'b00};
                epoch_r    <= epoch_r + epoch_t'(1);
            end
            else if (issue) begin
                next_adr_r <= next_adr_r + XLEN'(4);
            end
        end
    end

    // address and epoch of the running cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            cyc_adr_r   <= next_adr_r;
            cyc_epoch_r <= epoch_r;     // old epoch kept if redirect comes later
        end
    end

    assign wb_o.cyc = cyc_r;
    assign wb_o.stb = cyc_r;
    assign wb_o.adr = cyc_adr_r;

    assign push_o            = done;    // room was reserved at issue
    assign push_word_o.addr  = cyc_adr_r;
    assign push_word_o.data  = wb_i.dat;
    assign push_word_o.epoch = cyc_epoch_r;

    // slot reservation means a push never meets a full queue
    a_push_room: assert property (@(posedge clk) disable iff (!reset_n)
        push_o |-> (queue_count_i < CNT_W'(QUEUE_DEPTH)));

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
/* fetch package
   widths and packed structs shared by the instruction fetch front end */
`default_nettype none

package fetch_pkg;

    localparam int XLEN    = 32;        // data and address width
    localparam int EPOCH_W = 3;         // bumped on every redirect

    typedef logic [EPOCH_W-1:0] epoch_t;

    // wishbone classic request, read only
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [XLEN-1:0] adr;          // word aligned
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    // one fetched memory word, 67 bits
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        epoch_t          epoch;        // epoch at start of bus cycle
    } fetch_word_t;

    // one instruction to decode, 65 bits
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;        // upper half zero when compressed
        logic            compressed;
    } fetch_insn_t;

endpackage

`default_nettype wire
